// File: bench/sid_chip_checker.sv
module sid_chip_checker (
    input logic local_clock,
    input logic rst,
    input logic cyc_i,
    input logic ack_o,
    input logic audio_p_o,
    input logic audio_n_o
);

    // failed assertions, read by the testbench at the end
    int fail_count = 0;

    // ------------------------------
    // output pair
    // ------------------------------
    // only one leg of the pair may pulse
    audio_legs_exclusive: assert property (
        @(posedge local_clock) disable iff (rst)
        !(audio_p_o && audio_n_o)
    ) else begin
        fail_count++;
        $error("audio_p_o and audio_n_o both high");
    end

    // ------------------------------
    // bus ack
    // ------------------------------
    // no cycle, no ack on the next edge
    ack_needs_cycle: assert property (
        @(posedge local_clock) disable iff (rst)
        !cyc_i |=> !ack_o
    ) else begin
        fail_count++;
        $error("ack_o high one cycle after cyc_i low");
    end

    // ack cleared by reset
    ack_low_after_reset: assert property (
        @(posedge local_clock)
        $fell(rst) |-> !ack_o
    ) else begin
        fail_count++;
        $error("ack_o high when reset released");
    end

endmodule

bind sid_chip sid_chip_checker u_checker (
    .local_clock(local_clock),
    .rst        (rst),
    .cyc_i      (cyc_i),
    .ack_o      (ack_o),
    .audio_p_o  (audio_p_o),
    .audio_n_o  (audio_n_o)
);

// File: bench/sid_chip_tb.sv
`include "sid_macros.svh"

module sid_chip_tb;

    localparam int CLK_PERIOD    = 40;
    localparam int NUM_ENTRIES   = 38;
    localparam int AUDIO_WINDOW  = 80000;
    localparam int MUTE_SETTLE   = 200;
    localparam int MUTE_WINDOW   = 5000;
    // table at 4 cycles per entry, two audio windows, mute check, margin
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 4 + 2 * AUDIO_WINDOW
                                    + MUTE_SETTLE + MUTE_WINDOW + 20000;
    localparam sid_bus_pkg::bus_addr_t BASE = 16'h0400;

    // one bus access and what it should return
    typedef struct packed {
        sid_bus_pkg::bus_addr_t adr;
        logic                   we;
        sid_bus_pkg::bus_data_t dat;
        sid_bus_pkg::bus_data_t exp_dat;
        logic                   exp_ack;
    } bus_entry_t;

    logic                   local_clock = 1'b0;
    logic                   rst = 1'b1;
    sid_bus_pkg::bus_addr_t adr_i = '0;
    sid_bus_pkg::bus_data_t dat_i = '0;
    logic                   we_i = 1'b0;
    logic                   stb_i = 1'b0;
    logic                   cyc_i = 1'b0;
    sid_bus_pkg::bus_data_t dat_o;
    logic                   ack_o;
    logic                   audio_p_o;
    logic                   audio_n_o;

    bus_entry_t             table_q [NUM_ENTRIES];
    int                     n_entries = 0;
    int                     error_count = 0;
    integer                 seed = 9651;

    sid_chip #(
        .BASE_ADDRESS(BASE)
    ) u_sid_chip (
        .local_clock(local_clock),
        .rst        (rst),
        .adr_i      (adr_i),
        .dat_i      (dat_i),
        .we_i       (we_i),
        .stb_i      (stb_i),
        .cyc_i      (cyc_i),
        .dat_o      (dat_o),
        .ack_o      (ack_o),
        .audio_p_o  (audio_p_o),
        .audio_n_o  (audio_n_o)
    );

    always #(CLK_PERIOD / 2) local_clock = ~local_clock;

    // ------------------------------
    // helpers
    // ------------------------------
    // four-state compare, an x or z on the DUT side is a mismatch
    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] t=%0t %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic add_entry(input sid_bus_pkg::bus_addr_t adr, input logic we,
                             input sid_bus_pkg::bus_data_t dat,
                             input sid_bus_pkg::bus_data_t exp_dat, input logic exp_ack);
        table_q[n_entries] = '{adr: adr, we: we, dat: dat, exp_dat: exp_dat, exp_ack: exp_ack};
        n_entries++;
    endtask

    task automatic apply_reset();
        @(posedge local_clock);
        #2;
        rst   = 1'b1;
        stb_i = 1'b0;
        cyc_i = 1'b0;
        we_i  = 1'b0;
        repeat (5) @(posedge local_clock);
        #2;
        rst = 1'b0;
    endtask

    // single access, strobe held for one cycle
    task automatic apply_entry(input bus_entry_t e, input int idx);
        @(posedge local_clock);
        #2;
        adr_i = e.adr;
        dat_i = e.dat;
        we_i  = e.we;
        stb_i = 1'b1;
        cyc_i = 1'b1;
        @(posedge local_clock);
        // ack registered, read data still on the address
        @(negedge local_clock);
        check_value($sformatf("entry %0d adr 0x%04h ack", idx, e.adr), ack_o, e.exp_ack);
        if (!e.we)
            check_value($sformatf("entry %0d adr 0x%04h data", idx, e.adr), dat_o, e.exp_dat);
        @(posedge local_clock);
        #2;
        stb_i = 1'b0;
        cyc_i = 1'b0;
        we_i  = 1'b0;
    endtask

    task automatic write_reg(input sid_bus_pkg::reg_addr_t off, input sid_bus_pkg::bus_data_t dat);
        bus_entry_t e;
        e = '{adr: BASE | 16'(off), we: 1'b1, dat: dat, exp_dat: '0, exp_ack: 1'b1};
        apply_entry(e, -1);
    endtask

    task automatic count_pulses(input int cycles, output int pulses);
        pulses = 0;
        repeat (cycles) begin
            @(negedge local_clock);
            if (audio_p_o || audio_n_o)
                pulses++;
        end
    endtask

    task automatic wait_first_pulse(input int limit, output int found);
        int n;
        found = 0;
        n     = 0;
        while (!found && n < limit) begin
            @(negedge local_clock);
            if (audio_p_o || audio_n_o)
                found = 1;
            n++;
        end
    endtask

    // ------------------------------
    // stimulus table
    // ------------------------------
    task automatic build_table();
        sid_bus_pkg::reg_addr_t offs [8];
        sid_bus_pkg::bus_data_t rst_vals [8];
        sid_bus_pkg::bus_data_t wr_vals [8];
        sid_bus_pkg::bus_addr_t bad_adr [3];
        offs     = '{`SID_OFF_FREQ_L, `SID_OFF_FREQ_H, `SID_OFF_PW_L, `SID_OFF_PW_H,
                     `SID_OFF_CONTROL, `SID_OFF_ATTDEC, `SID_OFF_SSTREL, `SID_OFF_MODEVOL};
        // freq 60000, pw 2048, saw+tri, sustain 8, volume 15
        rst_vals = '{8'h60, 8'hEA, 8'h00, 8'h08, 8'h30, 8'h00, 8'h80, 8'h0F};
        // in-window hole, and two addresses outside the window
        bad_adr  = '{16'h0410, 16'h0000, 16'h0824};
        for (int i = 0; i < 8; i++)
            add_entry(BASE | 16'(offs[i]), 1'b0, 8'h00, rst_vals[i], 1'b1);
        for (int i = 0; i < 8; i++) begin
            wr_vals[i] = $random(seed);
            add_entry(BASE | 16'(offs[i]), 1'b1, wr_vals[i], 8'h00, 1'b1);
        end
        // volume register is only a nibble
        wr_vals[7] = {4'h0, wr_vals[7][3:0]};
        for (int i = 0; i < 8; i++)
            add_entry(BASE | 16'(offs[i]), 1'b0, 8'h00, wr_vals[i], 1'b1);
        for (int i = 0; i < 3; i++)
            add_entry(bad_adr[i], 1'b1, 8'($random(seed)), 8'h00, 1'b0);
        for (int i = 0; i < 3; i++)
            add_entry(bad_adr[i], 1'b0, 8'h00, 8'h00, 1'b0);
        // registers untouched by the stray writes
        for (int i = 0; i < 8; i++)
            add_entry(BASE | 16'(offs[i]), 1'b0, 8'h00, wr_vals[i], 1'b1);
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        int pulses;
        int found;
        int total;
        build_table();
        if (n_entries != NUM_ENTRIES)
            check_value("table size", n_entries, NUM_ENTRIES);
        apply_reset();
        for (int i = 0; i < n_entries; i++)
            apply_entry(table_q[i], i);

        // fresh reset, gate off
        apply_reset();
        count_pulses(AUDIO_WINDOW, pulses);
        check_value("audio pulses with gate off", pulses, 0);

        // saw plus gate at full volume
        write_reg(`SID_OFF_CONTROL, 8'h21);
        write_reg(`SID_OFF_MODEVOL, 8'h0F);
        wait_first_pulse(AUDIO_WINDOW, found);
        check_value("audio pulse with gate on", found, 1);

        // mute and let the pipeline drain
        write_reg(`SID_OFF_MODEVOL, 8'h00);
        repeat (MUTE_SETTLE) @(posedge local_clock);
        count_pulses(MUTE_WINDOW, pulses);
        check_value("audio pulses at volume 0", pulses, 0);

        total = error_count + u_sid_chip.u_checker.fail_count;
        $display("errors: %0d check errors, %0d assertion failures",
                 error_count, u_sid_chip.u_checker.fail_count);
        if (total == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: test sequence did not finish after %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: logic/sid_audio_out.sv
`include "sid_macros.svh"

module sid_audio_out (
    input  logic                      local_clock,
    input  logic                      rst,
    input  logic                      sample_tick_i,
    input  sid_voice_pkg::sample_t    wave_i,
    input  sid_voice_pkg::env_level_t level_i,
    input  sid_voice_pkg::nibble_t    volume_i,
    output logic                      audio_p_o,
    output logic                      audio_n_o
);

    logic signed [15:0]     voice_prod_q;
    logic signed [13:0]     vol_prod_q;
    sid_voice_pkg::sample_t voice_scaled;
    sid_voice_pkg::sample_t audio_scaled;
    logic                   audio_neg;
    logic [8:0]             audio_abs;
    logic [15:0]            acc_q;
    logic [15:0]            acc_sum;
    logic                   pulse_q;

    // ------------------------------
    // two-stage scaling
    // ------------------------------
    // drop the 6 envelope fraction bits
    assign voice_scaled = voice_prod_q[14:6];
    // volume is 4 fraction bits
    assign audio_scaled = vol_prod_q[12:4];

    assign audio_neg = audio_scaled[8];
    assign audio_abs = audio_neg ? -audio_scaled : audio_scaled;
    assign acc_sum   = acc_q + 16'(audio_abs);

    always_ff @(posedge local_clock or posedge rst) begin
        if (rst) begin
            voice_prod_q <= '0;
            vol_prod_q   <= '0;
        end else if (sample_tick_i) begin
            voice_prod_q <= wave_i * $signed({1'b0, level_i});
            vol_prod_q   <= voice_scaled * $signed({1'b0, volume_i});
        end
    end

    // ------------------------------
    // first-order sigma-delta, every cycle
    // ------------------------------
    always_ff @(posedge local_clock or posedge rst) begin
        if (rst) begin
            acc_q   <= '0;
            pulse_q <= 1'b0;
        end else if (acc_sum >= 16'(`SID_SD_THRESHOLD)) begin
            acc_q   <= acc_sum - 16'(`SID_SD_THRESHOLD);
            pulse_q <= 1'b1;
        end else begin
            acc_q   <= acc_sum;
            pulse_q <= 1'b0;
        end
    end

    // sign picks the leg
    assign audio_p_o = audio_neg ? 1'b0 : pulse_q;
    assign audio_n_o = audio_neg ? pulse_q : 1'b0;

endmodule

// File: logic/sid_bus_pkg.sv
package sid_bus_pkg;

    // full bus address
    typedef logic [15:0] bus_addr_t;

    // offset within the register window
    typedef logic [4:0] reg_addr_t;

    // bus data byte
    typedef logic [7:0] bus_data_t;

    // ------------------------------
    // one bus request, as sampled from the ports
    // ------------------------------
    typedef struct packed {
        bus_addr_t adr;
        bus_data_t dat;
        logic      we;
        logic      stb;
        logic      cyc;
    } bus_req_t;

endpackage

// File: logic/sid_chip.sv
module sid_chip #(
    parameter sid_bus_pkg::bus_addr_t BASE_ADDRESS = '0
) (
    input  logic                   local_clock,
    input  logic                   rst,
    input  sid_bus_pkg::bus_addr_t adr_i,
    input  sid_bus_pkg::bus_data_t dat_i,
    input  logic                   we_i,
    input  logic                   stb_i,
    input  logic                   cyc_i,
    output sid_bus_pkg::bus_data_t dat_o,
    output logic                   ack_o,
    output logic                   audio_p_o,
    output logic                   audio_n_o
);

    sid_bus_pkg::bus_req_t      bus_req;
    sid_voice_pkg::voice_regs_t voice_regs;
    sid_voice_pkg::nibble_t     volume;
    logic                       sample_tick;
    logic                       env_tick;
    sid_voice_pkg::sample_t     wave;
    sid_voice_pkg::env_level_t  env_level;

    // bus ports into one request
    assign bus_req = '{adr: adr_i, dat: dat_i, we: we_i, stb: stb_i, cyc: cyc_i};

    // ------------------------------
    // register decode
    // ------------------------------
    sid_reg_decode #(
        .BASE_ADDRESS(BASE_ADDRESS)
    ) u_reg_decode (
        .local_clock(local_clock),
        .rst        (rst),
        .bus_req_i  (bus_req),
        .dat_o      (dat_o),
        .ack_o      (ack_o),
        .voice_o    (voice_regs),
        .volume_o   (volume)
    );

    sid_tick_gen u_tick_gen (
        .local_clock  (local_clock),
        .rst          (rst),
        .sample_tick_o(sample_tick),
        .env_tick_o   (env_tick)
    );

    // ------------------------------
    // voice and output
    // ------------------------------
    sid_oscillator u_oscillator (
        .local_clock  (local_clock),
        .rst          (rst),
        .sample_tick_i(sample_tick),
        .voice_i      (voice_regs),
        .wave_o       (wave)
    );

    sid_envelope u_envelope (
        .local_clock(local_clock),
        .rst        (rst),
        .env_tick_i (env_tick),
        .voice_i    (voice_regs),
        .level_o    (env_level)
    );

    sid_audio_out u_audio_out (
        .local_clock  (local_clock),
        .rst          (rst),
        .sample_tick_i(sample_tick),
        .wave_i       (wave),
        .level_i      (env_level),
        .volume_i     (volume),
        .audio_p_o    (audio_p_o),
        .audio_n_o    (audio_n_o)
    );

endmodule

// File: logic/sid_envelope.sv
`include "sid_macros.svh"

module sid_envelope (
    input  logic                       local_clock,
    input  logic                       rst,
    input  logic                       env_tick_i,
    input  sid_voice_pkg::voice_regs_t voice_i,
    output sid_voice_pkg::env_level_t  level_o
);

    localparam sid_voice_pkg::env_level_t LVL_MAX = '1;

    // ------------------------------
    // step periods in envelope ticks
    // ------------------------------
    // 0..15 attack, 16..31 decay or release
    localparam logic [13:0] RATE_TABLE [32] = '{
        14'd1,    14'd4,    14'd8,    14'd12,   14'd19,   14'd28,   14'd34,   14'd40,
        14'd50,   14'd125,  14'd250,  14'd400,  14'd500,  14'd1500, 14'd2500, 14'd4000,
        14'd3,    14'd12,   14'd24,   14'd36,   14'd57,   14'd84,   14'd102,  14'd120,
        14'd150,  14'd375,  14'd750,  14'd1200, 14'd1500, 14'd4500, 14'd7500, 14'd12000
    };

    sid_voice_pkg::env_state_e state_q;
    sid_voice_pkg::env_state_e state_d;
    sid_voice_pkg::env_level_t level_q;
    sid_voice_pkg::env_level_t level_d;
    logic [13:0]               cnt_q;
    logic [13:0]               cnt_d;
    logic [4:0]                rate_sel;
    logic [3:0]                level_top;

    // compared against sustain
    assign level_top = level_q[`SID_ENV_W-1 -: 4];

    always_comb begin
        case (state_q)
            sid_voice_pkg::ENV_ATTACK:  rate_sel = {1'b0, voice_i.attack_rate};
            sid_voice_pkg::ENV_DECAY:   rate_sel = {1'b1, voice_i.decay_rate};
            sid_voice_pkg::ENV_SUSTAIN: rate_sel = 5'h00;
            default:                    rate_sel = {1'b1, voice_i.release_rate};
        endcase
    end

    // ------------------------------
    // level step and state change
    // ------------------------------
    always_comb begin
        state_d = state_q;
        level_d = level_q;
        cnt_d   = cnt_q;
        if (cnt_q != '0) begin
            cnt_d = cnt_q - 1'b1;
        end else begin
            case (state_q)
                sid_voice_pkg::ENV_ATTACK: begin
                    if (level_q != LVL_MAX)
                        level_d = level_q + 1'b1;
                end
                sid_voice_pkg::ENV_DECAY: begin
                    if (level_top > voice_i.sustain_lvl)
                        level_d = level_q - 1'b1;
                end
                sid_voice_pkg::ENV_RELEASE: begin
                    if (level_q != '0)
                        level_d = level_q - 1'b1;
                end
                default: ;
            endcase
            // reload period for the current phase
            cnt_d = RATE_TABLE[rate_sel];
        end

        // gate low always releases
        if (!voice_i.gate) begin
            state_d = sid_voice_pkg::ENV_RELEASE;
        end else begin
            case (state_q)
                sid_voice_pkg::ENV_RELEASE: state_d = sid_voice_pkg::ENV_ATTACK;
                sid_voice_pkg::ENV_ATTACK: begin
                    if (level_q == LVL_MAX)
                        state_d = sid_voice_pkg::ENV_DECAY;
                end
                sid_voice_pkg::ENV_DECAY: begin
                    if (level_top <= voice_i.sustain_lvl)
                        state_d = sid_voice_pkg::ENV_SUSTAIN;
                end
                default: begin
                    // sustain raised above level, decay again
                    if (level_top > voice_i.sustain_lvl)
                        state_d = sid_voice_pkg::ENV_DECAY;
                end
            endcase
        end
    end

    always_ff @(posedge local_clock or posedge rst) begin
        if (rst) begin
            state_q <= sid_voice_pkg::ENV_RELEASE;
            level_q <= '0;
            cnt_q   <= '0;
        end else if (env_tick_i) begin
            state_q <= state_d;
            level_q <= level_d;
            cnt_q   <= cnt_d;
        end
    end

    assign level_o = level_q;

endmodule

// File: logic/sid_macros.svh
`ifndef SID_MACROS_SVH
`define SID_MACROS_SVH

// ------------------------------
// register offsets inside the 32-byte window
// ------------------------------
`define SID_OFF_FREQ_L    5'h00
`define SID_OFF_FREQ_H    5'h01
`define SID_OFF_PW_L      5'h02
`define SID_OFF_PW_H      5'h03
`define SID_OFF_CONTROL   5'h04
`define SID_OFF_ATTDEC    5'h05
`define SID_OFF_SSTREL    5'h06
`define SID_OFF_MODEVOL   5'h18

// local_clock cycles per sample tick
`define SID_SAMPLE_DIV    24
// sample ticks per envelope tick
`define SID_ENV_DIV       16

// datapath widths
`define SID_PHASE_W       23
`define SID_AVG_W         24
`define SID_PRBS_W        24
`define SID_ENV_W         6

// register reset values
`define SID_RST_FREQ      16'd60000
`define SID_RST_PW        12'd2048
`define SID_RST_SUSTAIN   4'd8
`define SID_RST_VOLUME    4'd15
`define SID_PRBS_SEED     42

// modulator threshold
`define SID_SD_THRESHOLD  128

`endif

// File: logic/sid_oscillator.sv
`include "sid_macros.svh"

module sid_oscillator (
    input  logic                       local_clock,
    input  logic                       rst,
    input  logic                       sample_tick_i,
    input  sid_voice_pkg::voice_regs_t voice_i,
    output sid_voice_pkg::sample_t     wave_o
);

    logic [`SID_PHASE_W-1:0] phase_q;
    logic                    step_bit_q;
    logic                    step;
    sid_voice_pkg::pw_t      pw_q;
    logic [`SID_PRBS_W-1:0]  prbs_q;
    logic [`SID_AVG_W-1:0]   avg_q;
    logic [7:0]              avg_top;
    logic [7:0]              pos;
    logic [7:0]              tri_w;
    logic [7:0]              pulse_w;
    logic [7:0]              wave_d;
    logic [7:0]              wave_q;

    // ------------------------------
    // phase and step detect
    // ------------------------------
    // rising edge of phase bit 17, seen on a sample tick
    assign step = sample_tick_i & phase_q[`SID_PHASE_W-6] & ~step_bit_q;
    assign pos  = phase_q[`SID_PHASE_W-1 -: 8];

    // ------------------------------
    // waveforms from the top phase byte
    // ------------------------------
    // fold upper half back down, x2
    assign tri_w   = {(pos[7] ? ~pos[6:0] : pos[6:0]), 1'b0};
    assign pulse_w = (pos > pw_q[11:4]) ? 8'h00 : 8'hFF;

    always_comb begin
        if (voice_i.noise | voice_i.pulse | voice_i.saw | voice_i.triangle) begin
            // unselected waves pass all ones into the and
            wave_d = (voice_i.saw      ? pos                          : 8'hFF) &
                     (voice_i.triangle ? tri_w                        : 8'hFF) &
                     (voice_i.pulse    ? pulse_w                      : 8'hFF) &
                     (voice_i.noise    ? prbs_q[`SID_PRBS_W-1 -: 8]   : 8'hFF);
        end else begin
            // no wave selected, mid-level
            wave_d = 8'h7F;
        end
    end

    assign avg_top = avg_q[`SID_AVG_W-1 -: 8];

    always_ff @(posedge local_clock or posedge rst) begin
        if (rst) begin
            phase_q    <= '0;
            step_bit_q <= 1'b0;
            pw_q       <= `SID_RST_PW;
            prbs_q     <= `SID_PRBS_W'(`SID_PRBS_SEED);
            wave_q     <= 8'h7F;
            avg_q      <= `SID_AVG_W'(1) << (`SID_AVG_W - 2);
        end else if (sample_tick_i) begin
            phase_q    <= phase_q + `SID_PHASE_W'(voice_i.freq);
            step_bit_q <= phase_q[`SID_PHASE_W-6];
            // pw and noise move once per step
            if (step) begin
                pw_q   <= voice_i.pw;
                prbs_q <= {prbs_q[`SID_PRBS_W-2:0],
                           prbs_q[`SID_PRBS_W-1] ^ prbs_q[`SID_PRBS_W-2]};
            end
            wave_q <= wave_d;
            // leaky running average, 1/65536 per sample
            avg_q  <= avg_q - `SID_AVG_W'(avg_top) + `SID_AVG_W'(wave_q);
        end
    end

    // dc removal
    assign wave_o = $signed({1'b0, wave_q}) - $signed({1'b0, avg_top});

endmodule

// File: logic/sid_reg_decode.sv
`include "sid_macros.svh"

module sid_reg_decode #(
    parameter sid_bus_pkg::bus_addr_t BASE_ADDRESS = '0
) (
    input  logic                       local_clock,
    input  logic                       rst,
    input  sid_bus_pkg::bus_req_t      bus_req_i,
    output sid_bus_pkg::bus_data_t     dat_o,
    output logic                       ack_o,
    output sid_voice_pkg::voice_regs_t voice_o,
    output sid_voice_pkg::nibble_t     volume_o
);

    // saw and triangle on, sustain half way
    localparam sid_voice_pkg::voice_regs_t RST_REGS = '{
        freq:        `SID_RST_FREQ,
        pw:          `SID_RST_PW,
        saw:         1'b1,
        triangle:    1'b1,
        sustain_lvl: `SID_RST_SUSTAIN,
        default:     '0
    };

    sid_bus_pkg::reg_addr_t     offset;
    logic                       in_window;
    logic                       mapped;
    sid_voice_pkg::voice_regs_t regs_q;
    sid_voice_pkg::nibble_t     volume_q;

    // window match on the upper address bits
    assign in_window = bus_req_i.adr[15:5] == BASE_ADDRESS[15:5];
    assign offset    = bus_req_i.adr[4:0];

    // ------------------------------
    // readback mux, flags mapped offsets too
    // ------------------------------
    always_comb begin
        mapped = in_window;
        dat_o  = '0;
        case (offset)
            `SID_OFF_FREQ_L:  dat_o = regs_q.freq[7:0];
            `SID_OFF_FREQ_H:  dat_o = regs_q.freq[15:8];
            `SID_OFF_PW_L:    dat_o = regs_q.pw[7:0];
            `SID_OFF_PW_H:    dat_o = {regs_q.extra, regs_q.pw[11:8]};
            `SID_OFF_CONTROL: dat_o = regs_q[23:16];
            `SID_OFF_ATTDEC:  dat_o = {regs_q.attack_rate, regs_q.decay_rate};
            `SID_OFF_SSTREL:  dat_o = {regs_q.sustain_lvl, regs_q.release_rate};
            `SID_OFF_MODEVOL: dat_o = {4'h0, volume_q};
            default:          mapped = 1'b0;
        endcase
        // nothing outside the window
        if (!mapped)
            dat_o = '0;
    end

    // ------------------------------
    // register writes and ack
    // ------------------------------
    always_ff @(posedge local_clock or posedge rst) begin
        if (rst) begin
            regs_q   <= RST_REGS;
            volume_q <= `SID_RST_VOLUME;
            ack_o    <= 1'b0;
        end else begin
            ack_o <= bus_req_i.cyc & bus_req_i.stb & mapped;
            if (bus_req_i.cyc && bus_req_i.stb && bus_req_i.we && mapped) begin
                case (offset)
                    `SID_OFF_FREQ_L:  regs_q.freq[7:0]  <= bus_req_i.dat;
                    `SID_OFF_FREQ_H:  regs_q.freq[15:8] <= bus_req_i.dat;
                    `SID_OFF_PW_L:    regs_q.pw[7:0]    <= bus_req_i.dat;
                    `SID_OFF_PW_H:    {regs_q.extra, regs_q.pw[11:8]} <= bus_req_i.dat;
                    // control byte sits at bits 23..16 of the bundle
                    `SID_OFF_CONTROL: regs_q[23:16] <= bus_req_i.dat;
                    `SID_OFF_ATTDEC:  {regs_q.attack_rate, regs_q.decay_rate} <= bus_req_i.dat;
                    `SID_OFF_SSTREL:  {regs_q.sustain_lvl, regs_q.release_rate} <= bus_req_i.dat;
                    // filter mode bits not kept
                    `SID_OFF_MODEVOL: volume_q <= bus_req_i.dat[3:0];
                    default: ;
                endcase
            end
        end
    end

    assign voice_o  = regs_q;
    assign volume_o = volume_q;

endmodule

// File: logic/sid_tick_gen.sv
`include "sid_macros.svh"

module sid_tick_gen (
    input  logic local_clock,
    input  logic rst,
    output logic sample_tick_o,
    output logic env_tick_o
);

    localparam int SMP_W = $clog2(`SID_SAMPLE_DIV);
    localparam int ENV_CNT_W = $clog2(`SID_ENV_DIV);

    logic [SMP_W-1:0]     smp_cnt;
    logic [ENV_CNT_W-1:0] env_cnt;

    // one-cycle pulses at terminal count
    assign sample_tick_o = smp_cnt == '0;
    assign env_tick_o    = sample_tick_o && env_cnt == '0;

    always_ff @(posedge local_clock or posedge rst) begin
        if (rst) begin
            smp_cnt <= SMP_W'(`SID_SAMPLE_DIV - 1);
            env_cnt <= ENV_CNT_W'(`SID_ENV_DIV - 1);
        end else begin
            if (sample_tick_o)
                smp_cnt <= SMP_W'(`SID_SAMPLE_DIV - 1);
            else
                smp_cnt <= smp_cnt - 1'b1;
            // envelope divider counts sample ticks
            if (sample_tick_o) begin
                if (env_cnt == '0)
                    env_cnt <= ENV_CNT_W'(`SID_ENV_DIV - 1);
                else
                    env_cnt <= env_cnt - 1'b1;
            end
        end
    end

endmodule

// File: logic/sid_voice_pkg.sv
`include "sid_macros.svh"

package sid_voice_pkg;

    typedef logic [15:0] freq_t;
    typedef logic [11:0] pw_t;
    // rates, sustain level, master volume
    typedef logic [3:0] nibble_t;
    // dc-free voice sample
    typedef logic signed [8:0] sample_t;
    typedef logic [`SID_ENV_W-1:0] env_level_t;

    // envelope phases, release doubles as idle
    typedef enum logic [1:0] {
        ENV_RELEASE,
        ENV_ATTACK,
        ENV_DECAY,
        ENV_SUSTAIN
    } env_state_e;

    // ------------------------------
    // voice register bundle
    // ------------------------------
    typedef struct packed {
        freq_t   freq;
        pw_t     pw;
        nibble_t extra;
        // control byte, msb first
        logic    noise;
        logic    pulse;
        logic    saw;
        logic    triangle;
        logic    test;
        logic    ringmod;
        logic    sync;
        logic    gate;
        nibble_t attack_rate;
        nibble_t decay_rate;
        nibble_t sustain_lvl;
        nibble_t release_rate;
    } voice_regs_t;

endpackage

// File: vlog.f
+incdir+logic
logic/sid_bus_pkg.sv
logic/sid_voice_pkg.sv
logic/sid_reg_decode.sv
logic/sid_tick_gen.sv
logic/sid_oscillator.sv
logic/sid_envelope.sv
logic/sid_audio_out.sv
logic/sid_chip.sv
bench/sid_chip_checker.sv
bench/sid_chip_tb.sv
